//--- router_macros.svh
// grid size, field width and fifo depth macros for the mesh router

`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// tile grid, columns west to east and rows north to south
`define FAB_COLS 3
`define FAB_ROWS 3

// total tiles in the grid
`define NUM_TILES 9

// width of one tile coordinate
`define ID_W 4

// payload word carried by each transaction
`define DATA_W 16

// entries per router input buffer
`define FIFO_DEPTH 2

`endif

//--- router_pkg.sv
// router_pkg with the tile id, transaction and port direction types
`default_nettype none

`include "router_macros.svh"

package router_pkg;

    // grid position, both fields count from 1
    typedef struct packed {
        logic [`ID_W-1:0] col;
        logic [`ID_W-1:0] row;
    } t_tile_id;

    // one transaction on a link, 32 bits in all
    typedef struct packed {
        t_tile_id          src;
        t_tile_id          dst;
        logic [`DATA_W-1:0] data;
    } t_tile_trans;

    // router port, also the bit position in request and grant vectors
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_port;

endpackage

`default_nettype wire

//--- tile_link_if.sv
// tile_link_if valid/ready link between two routers, with sender and receiver modports
`timescale 1ns/1ps
`default_nettype none

interface tile_link_if;

    // transfer on a clock edge with valid and ready both high
    logic                    valid;
    logic                    ready;
    router_pkg::t_tile_trans trans;

    // upstream side holds valid and trans until the transfer
    modport sender (
        output valid,
        output trans,
        input  ready
    );

    modport receiver (
        input  valid,
        input  trans,
        output ready
    );

endinterface

`default_nettype wire

//--- trans_fifo.sv
// trans_fifo circular input buffer of one router port with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module trans_fifo (
    input  logic                    clk,
    input  logic                    reset,
    tile_link_if.receiver           in_link,
    output logic                    out_valid,
    output router_pkg::t_tile_trans out_trans,
    input  logic                    out_pop
);
    import router_pkg::*;

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    t_tile_trans      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    // full is the only reason to refuse
    assign in_link.ready = (count != FULL_COUNT);
    assign push          = in_link.valid && in_link.ready;

    assign out_valid = (count != '0);
    assign out_trans = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_link.trans;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (out_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves the count alone
            if (push && !out_pop) begin
                count <= count + 1'b1;
            end else if (out_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // a push into a full buffer would run the count past the depth
    assert property (@(posedge clk) disable iff (reset)
        count <= FULL_COUNT);

    // the crossbar must only pop a head it has seen
    assert property (@(posedge clk) disable iff (reset)
        (count == '0) |-> !out_pop);

endmodule

`default_nettype wire

//--- rr_arbiter.sv
// rr_arbiter round-robin choice among five input ports, grant held while the output stalls
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] req,
    input  logic       hold,
    output logic [4:0] grant
);
    localparam int NUM_REQ = 5;

    logic [2:0] last_q;
    logic       held_q;
    logic [4:0] grant_q;
    logic [4:0] pick;

    // first requester after the last winner, wrapping around
    always_comb begin
        int   idx;
        logic found;
        pick  = '0;
        found = 1'b0;
        for (int i = 1; i <= NUM_REQ; i++) begin
            idx = (int'(last_q) + i) % NUM_REQ;
            if (!found && req[idx]) begin
                pick[idx] = 1'b1;
                found     = 1'b1;
            end
        end
    end

    // a stalled winner keeps the output until its transfer
    assign grant = held_q ? grant_q : pick;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q  <= 3'd4;
            held_q  <= 1'b0;
            grant_q <= '0;
        end else begin
            held_q  <= hold;
            grant_q <= grant;
            // granted and not held means the transfer happened
            if (|grant && !hold) begin
                for (int k = 0; k < NUM_REQ; k++) begin
                    if (grant[k]) begin
                        last_q <= 3'(k);
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

`default_nettype wire

//--- mini_core_tile.sv
// mini_core_tile router with five input fifos, xy route logic, output arbiters and crossbar
`timescale 1ns/1ps
`default_nettype none

module mini_core_tile (
    input  logic                 clk,
    input  logic                 reset,
    input  router_pkg::t_tile_id local_tile_id,
    tile_link_if.receiver        north_in,
    tile_link_if.receiver        east_in,
    tile_link_if.receiver        south_in,
    tile_link_if.receiver        west_in,
    tile_link_if.receiver        local_in,
    tile_link_if.sender          north_out,
    tile_link_if.sender          east_out,
    tile_link_if.sender          south_out,
    tile_link_if.sender          west_out,
    tile_link_if.sender          local_out
);
    import router_pkg::*;

    localparam int NUM_PORTS = 5;

    // fifo heads, indexed by input port
    logic [4:0]  head_valid;
    t_tile_trans head_trans [NUM_PORTS];
    t_port       head_dir   [NUM_PORTS];
    logic [4:0]  head_pop;

    // per output port, bit i of a vector stands for input i
    logic [4:0]  req_to [NUM_PORTS];
    logic [4:0]  grant  [NUM_PORTS];
    logic [4:0]  out_valid;
    logic [4:0]  out_ready;
    logic [4:0]  hold;
    t_tile_trans out_trans [NUM_PORTS];

    // column first, then row
    function automatic t_port route(input t_tile_id dst, input t_tile_id here);
        if (dst.col > here.col) begin
            route = EAST;
        end else if (dst.col < here.col) begin
            route = WEST;
        end else if (dst.row > here.row) begin
            route = SOUTH;
        end else if (dst.row < here.row) begin
            route = NORTH;
        end else begin
            route = LOCAL;
        end
    endfunction

    trans_fifo u_fifo_north (
        .clk       (clk),
        .reset     (reset),
        .in_link   (north_in),
        .out_valid (head_valid[NORTH]),
        .out_trans (head_trans[NORTH]),
        .out_pop   (head_pop[NORTH])
    );

    trans_fifo u_fifo_east (
        .clk       (clk),
        .reset     (reset),
        .in_link   (east_in),
        .out_valid (head_valid[EAST]),
        .out_trans (head_trans[EAST]),
        .out_pop   (head_pop[EAST])
    );

    trans_fifo u_fifo_south (
        .clk       (clk),
        .reset     (reset),
        .in_link   (south_in),
        .out_valid (head_valid[SOUTH]),
        .out_trans (head_trans[SOUTH]),
        .out_pop   (head_pop[SOUTH])
    );

    trans_fifo u_fifo_west (
        .clk       (clk),
        .reset     (reset),
        .in_link   (west_in),
        .out_valid (head_valid[WEST]),
        .out_trans (head_trans[WEST]),
        .out_pop   (head_pop[WEST])
    );

    trans_fifo u_fifo_local (
        .clk       (clk),
        .reset     (reset),
        .in_link   (local_in),
        .out_valid (head_valid[LOCAL]),
        .out_trans (head_trans[LOCAL]),
        .out_pop   (head_pop[LOCAL])
    );

    // route each head and spread it into the request vectors
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            head_dir[i] = route(head_trans[i].dst, local_tile_id);
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req_to[o][i] = head_valid[i] && (head_dir[i] == t_port'(o));
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
        rr_arbiter u_arb (
            .clk   (clk),
            .reset (reset),
            .req   (req_to[o]),
            .hold  (hold[o]),
            .grant (grant[o])
        );
    end

    // crossbar, an accepted output pops its winner
    always_comb begin
        head_pop = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_valid[o] = |grant[o];
            out_trans[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant[o][i]) begin
                    out_trans[o] = head_trans[i];
                    if (out_ready[o]) begin
                        head_pop[i] = 1'b1;
                    end
                end
            end
            hold[o] = out_valid[o] && !out_ready[o];
        end
    end

    assign north_out.valid  = out_valid[NORTH];
    assign north_out.trans  = out_trans[NORTH];
    assign out_ready[NORTH] = north_out.ready;
    assign east_out.valid   = out_valid[EAST];
    assign east_out.trans   = out_trans[EAST];
    assign out_ready[EAST]  = east_out.ready;
    assign south_out.valid  = out_valid[SOUTH];
    assign south_out.trans  = out_trans[SOUTH];
    assign out_ready[SOUTH] = south_out.ready;
    assign west_out.valid   = out_valid[WEST];
    assign west_out.trans   = out_trans[WEST];
    assign out_ready[WEST]  = west_out.ready;
    assign local_out.valid  = out_valid[LOCAL];
    assign local_out.trans  = out_trans[LOCAL];
    assign out_ready[LOCAL] = local_out.ready;

    // traffic from a neighbor never turns back toward it
    for (genvar i = 0; i < NUM_PORTS - 1; i++) begin : g_no_u_turn
        assert property (@(posedge clk) disable iff (reset)
            head_valid[i] |-> (head_dir[i] != t_port'(i)));
    end

endmodule

`default_nettype wire

//--- fabric.sv
// fabric top level, 3x3 grid of router tiles with edge tie-offs and per-tile local ports
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module fabric (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`NUM_TILES-1:0]                   inject_valid,
    input  router_pkg::t_tile_trans [`NUM_TILES-1:0] inject_trans,
    output logic [`NUM_TILES-1:0]                   inject_ready,
    output logic [`NUM_TILES-1:0]                   eject_valid,
    output router_pkg::t_tile_trans [`NUM_TILES-1:0] eject_trans,
    input  logic [`NUM_TILES-1:0]                   eject_ready
);
    import router_pkg::*;

    localparam int COLS = `FAB_COLS;
    localparam int ROWS = `FAB_ROWS;

    // links indexed by boundary, boundary b sits east of column b or south of row b
    // horizontal index is b*ROWS + row-1, vertical index is b*COLS + col-1
    tile_link_if east_bus  [(COLS + 1) * ROWS] ();
    tile_link_if west_bus  [(COLS + 1) * ROWS] ();
    tile_link_if south_bus [(ROWS + 1) * COLS] ();
    tile_link_if north_bus [(ROWS + 1) * COLS] ();

    for (genvar r = 1; r <= ROWS; r++) begin : row
        for (genvar c = 1; c <= COLS; c++) begin : col
            localparam int T = (r - 1) * COLS + (c - 1);
            localparam logic [`ID_W-1:0] TILE_COL = c;
            localparam logic [`ID_W-1:0] TILE_ROW = r;
            localparam t_tile_id TILE_ID = '{col: TILE_COL, row: TILE_ROW};

            tile_link_if local_in_link ();
            tile_link_if local_out_link ();

            assign local_in_link.valid  = inject_valid[T];
            assign local_in_link.trans  = inject_trans[T];
            assign inject_ready[T]      = local_in_link.ready;
            assign eject_valid[T]       = local_out_link.valid;
            assign eject_trans[T]       = local_out_link.trans;
            assign local_out_link.ready = eject_ready[T];

            mini_core_tile mini_core_tile_inst (
                .clk           (clk),
                .reset         (reset),
                .local_tile_id (TILE_ID),
                .north_in      (south_bus[(r - 1) * COLS + c - 1]),
                .east_in       (west_bus[c * ROWS + r - 1]),
                .south_in      (north_bus[r * COLS + c - 1]),
                .west_in       (east_bus[(c - 1) * ROWS + r - 1]),
                .local_in      (local_in_link),
                .north_out     (north_bus[(r - 1) * COLS + c - 1]),
                .east_out      (east_bus[c * ROWS + r - 1]),
                .south_out     (south_bus[r * COLS + c - 1]),
                .west_out      (west_bus[(c - 1) * ROWS + r - 1]),
                .local_out     (local_out_link)
            );
        end
    end

    // west and east edges
    for (genvar r = 1; r <= ROWS; r++) begin : g_row_edge
        assign east_bus[r - 1].valid           = 1'b0;
        assign east_bus[r - 1].trans           = '0;
        assign east_bus[COLS * ROWS + r - 1].ready = 1'b1;
        assign west_bus[COLS * ROWS + r - 1].valid = 1'b0;
        assign west_bus[COLS * ROWS + r - 1].trans = '0;
        assign west_bus[r - 1].ready           = 1'b1;

        assert property (@(posedge clk) disable iff (reset)
            !east_bus[COLS * ROWS + r - 1].valid && !west_bus[r - 1].valid);
    end

    // north and south edges
    for (genvar c = 1; c <= COLS; c++) begin : g_col_edge
        assign south_bus[c - 1].valid               = 1'b0;
        assign south_bus[c - 1].trans               = '0;
        assign south_bus[ROWS * COLS + c - 1].ready = 1'b1;
        assign north_bus[ROWS * COLS + c - 1].valid = 1'b0;
        assign north_bus[ROWS * COLS + c - 1].trans = '0;
        assign north_bus[c - 1].ready               = 1'b1;

        assert property (@(posedge clk) disable iff (reset)
            !south_bus[ROWS * COLS + c - 1].valid && !north_bus[c - 1].valid);
    end

endmodule

`default_nettype wire

//--- fabric_tb.sv
// fabric_tb testbench for the mesh fabric, file driven injection with eject stalls and per pair checks
`timescale 1ns/1ps
`default_nettype none

`include "router_macros.svh"

module fabric_tb;
    import router_pkg::*;

    localparam int FIELDS     = 7;
    localparam int MAX_LINES  = 64;
    localparam int NUM_PAIRS  = `NUM_TILES * `NUM_TILES;
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] SEED = 32'h8bf6;

    logic                                clk;
    logic                                reset;
    logic [`NUM_TILES-1:0]               inject_valid;
    t_tile_trans [`NUM_TILES-1:0]        inject_trans;
    logic [`NUM_TILES-1:0]               inject_ready;
    logic [`NUM_TILES-1:0]               eject_valid;
    t_tile_trans [`NUM_TILES-1:0]        eject_trans;
    logic [`NUM_TILES-1:0]               eject_ready;

    // one test line is seven hex words
    logic [15:0] test_mem [FIELDS * MAX_LINES];

    // expected traffic, one queue per destination and source pair
    t_tile_trans exp_q [NUM_PAIRS][$];
    int          pending;
    int          sent;
    int          delivered;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic        timed_out;

    fabric fabric_inst (
        .clk          (clk),
        .reset        (reset),
        .inject_valid (inject_valid),
        .inject_trans (inject_trans),
        .inject_ready (inject_ready),
        .eject_valid  (eject_valid),
        .eject_trans  (eject_trans),
        .eject_ready  (eject_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // tiles are numbered row major from the north west corner
    function automatic int tile_num(input t_tile_id id);
        return (int'(id.row) - 1) * `FAB_COLS + int'(id.col) - 1;
    endfunction

    function automatic logic id_in_grid(input t_tile_id id);
        return id.col >= 1 && id.col <= `FAB_COLS && id.row >= 1 && id.row <= `FAB_ROWS;
    endfunction

    function automatic int pair_index(input int dst, input int src);
        return dst * `NUM_TILES + src;
    endfunction

    // match one ejected transaction against the head of its pair queue
    task automatic check_eject(input int t, input t_tile_trans got);
        int          p;
        t_tile_trans want;
        if (!id_in_grid(got.src)) begin
            $display("FAILED at %0t: tile %0d ejected %h with a source outside the grid",
                     $time, t, got);
            errors++;
        end else begin
            p = pair_index(t, tile_num(got.src));
            if (exp_q[p].size() == 0) begin
                $display("FAILED at %0t: tile %0d ejected %h with nothing pending for that pair",
                         $time, t, got);
                errors++;
            end else begin
                want = exp_q[p].pop_front();
                pending--;
                delivered++;
                if (got !== want) begin
                    $display("FAILED at %0t: tile %0d ejected %h, expected %h",
                             $time, t, got, want);
                    errors++;
                end
            end
        end
    endtask

    // eject handshakes, sampled at the edge where they complete
    always @(posedge clk) begin
        if (!reset) begin
            for (int t = 0; t < `NUM_TILES; t++) begin
                if (eject_valid[t] && eject_ready[t]) begin
                    check_eject(t, eject_trans[t]);
                end
            end
        end
    end

    // called at a falling edge, returns at a falling edge
    task automatic inject_one(input int src, input t_tile_trans tr);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        exp_q[pair_index(tile_num(tr.dst), src)].push_back(tr);
        pending++;
        sent++;
        inject_valid[src] = 1'b1;
        inject_trans[src] = tr;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = inject_ready[src];
            waited++;
        end
        @(negedge clk);
        inject_valid[src] = 1'b0;
        if (!accepted) begin
            $display("timeout: tile %0d never accepted transaction %h", src, tr);
            timed_out = 1'b1;
        end
    endtask

    task automatic inject_line(input int line);
        int          base;
        int          gap;
        t_tile_trans tr;
        base       = line * FIELDS;
        tr.src.col = test_mem[base + 1][`ID_W-1:0];
        tr.src.row = test_mem[base + 2][`ID_W-1:0];
        tr.dst.col = test_mem[base + 3][`ID_W-1:0];
        tr.dst.row = test_mem[base + 4][`ID_W-1:0];
        tr.data    = test_mem[base + 5];
        inject_one(tile_num(tr.src), tr);
        gap = int'($urandom % 3);
        repeat (gap) @(negedge clk);
    endtask

    // every eject port held off, a waiting transaction must stay put
    task automatic apply_stall(input int cycles);
        logic [`NUM_TILES-1:0]        seen_valid;
        t_tile_trans [`NUM_TILES-1:0] seen_trans;
        if (cycles > 0) begin
            eject_ready = '0;
            seen_valid  = '0;
            seen_trans  = '0;
            repeat (cycles) begin
                @(negedge clk);
                for (int t = 0; t < `NUM_TILES; t++) begin
                    if (seen_valid[t]
                        && (!eject_valid[t] || eject_trans[t] !== seen_trans[t])) begin
                        $display("FAILED at %0t: tile %0d dropped or changed %h at eject %s",
                                 $time, t, seen_trans[t], "while eject_ready was low");
                        errors++;
                    end
                end
                seen_valid = eject_valid;
                seen_trans = eject_trans;
            end
            eject_ready = '1;
        end
    endtask

    task automatic wait_drain(input int test_id);
        int waited;
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: test %0d still has %0d transactions undelivered",
                     test_id, pending);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input int test_id, input int err_start, input int sent_start,
                               input int deliv_start);
        if (errors == err_start && !timed_out) begin
            tests_passed++;
            $display("test %0d: ok, %0d sent, %0d delivered", test_id,
                     sent - sent_start, delivered - deliv_start);
        end else begin
            tests_failed++;
            $display("test %0d: failed, %0d sent, %0d delivered", test_id,
                     sent - sent_start, delivered - deliv_start);
        end
    endtask

    initial begin
        int idx;
        int cur;
        int stall;
        int err_start;
        int sent_start;
        int deliv_start;
        void'($urandom(SEED));
        reset        = 1'b1;
        inject_valid = '0;
        inject_trans = '0;
        eject_ready  = '1;
        pending      = 0;
        sent         = 0;
        delivered    = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
            test_mem[i] = 16'hffff;
        end
        $readmemh("fabric_tests.txt", test_mem);

        repeat (5) @(negedge clk);
        reset = 1'b0;

        // test 0 is the idle state right after reset
        @(negedge clk);
        err_start = errors;
        if (eject_valid !== '0) begin
            $display("FAILED at %0t: eject_valid is %b after reset", $time, eject_valid);
            errors++;
        end
        if (inject_ready !== '1) begin
            $display("FAILED at %0t: inject_ready is %b after reset", $time, inject_ready);
            errors++;
        end
        report_test(0, err_start, sent, delivered);

        idx = 0;
        while (idx < MAX_LINES && test_mem[idx * FIELDS] != 16'hffff && !timed_out) begin
            cur         = int'(test_mem[idx * FIELDS]);
            stall       = int'(test_mem[idx * FIELDS + 6]);
            err_start   = errors;
            sent_start  = sent;
            deliv_start = delivered;
            fork
                apply_stall(stall);
                begin
                    while (idx < MAX_LINES && int'(test_mem[idx * FIELDS]) == cur
                           && !timed_out) begin
                        inject_line(idx);
                        idx++;
                    end
                end
            join
            if (!timed_out) begin
                wait_drain(cur);
            end
            report_test(cur, err_start, sent_start, deliv_start);
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fabric_tests.txt
// test src_col src_row dst_col dst_row data stall, all hex, one transaction per line
// stall counts eject cycles with every eject_ready low from the start of the test
01 1 1 2 1 a101 00
02 1 1 3 3 a202 00
03 2 3 2 3 a303 00
04 1 1 2 2 b111 00
04 2 1 2 2 b211 00
04 3 1 2 2 b311 00
04 1 2 2 2 b121 00
04 3 2 2 2 b321 00
04 1 3 2 2 b131 00
04 2 3 2 2 b231 00
04 3 3 2 2 b331 00
04 1 1 2 2 b112 00
04 2 1 2 2 b212 00
04 3 1 2 2 b312 00
04 1 2 2 2 b122 00
04 3 2 2 2 b322 00
04 1 3 2 2 b132 00
04 2 3 2 2 b232 00
04 3 3 2 2 b332 00
05 3 1 1 3 c001 0c
05 3 3 1 3 c002 0c
05 3 1 1 3 c003 0c
05 2 2 1 3 c004 0c
06 1 2 3 2 d001 00
06 3 2 1 2 d002 00
06 2 1 2 3 d003 00
06 2 3 2 1 d004 00
06 1 2 3 2 d005 00
06 3 2 1 2 d006 00

//--- filelist.f
+incdir+.
router_pkg.sv
tile_link_if.sv
trans_fifo.sv
rr_arbiter.sv
mini_core_tile.sv
fabric.sv
fabric_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module fabric_tb -o fabric_sim
./obj_dir/fabric_sim | tee sim.log
if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
